/* rtl/usb_ahb_pkg.sv */
`default_nettype none

package usb_ahb_pkg;

  // ********************************************************************
  // Bus and endpoint widths
  // ********************************************************************

  // AHB address width, covers data window and register block
  localparam int ADDR_W = 7;
  // AHB data width
  localparam int DATA_W = 32;
  // Occupancy and packet size width
  localparam int OCC_W  = 7;
  // Width of the halfword status and error registers
  localparam int HREG_W = 16;
  // Every register answers for a full word
  localparam int REG_SPAN = 4;

  // ********************************************************************
  // AHB-Lite bus codes
  // ********************************************************************

  // HTRANS encoding
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    BUSY   = 2'd1,
    NONSEQ = 2'd2,
    SEQ    = 2'd3
  } htrans_e;

  // HSIZE encoding, also the buffer data size
  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } hsize_e;

  // ********************************************************************
  // Register map
  // ********************************************************************

  // Data window runs from 0x00 up to here
  localparam logic [ADDR_W-1:0] BUF_LAST    = 7'h3F;
  // Read-only endpoint status halfword
  localparam logic [ADDR_W-1:0] STATUS_ADDR = 7'h40;
  // Read-only error flags halfword
  localparam logic [ADDR_W-1:0] ERROR_ADDR  = 7'h42;
  // Read-only buffer occupancy
  localparam logic [ADDR_W-1:0] OCC_ADDR    = 7'h44;
  // Read/write transmit packet size
  localparam logic [ADDR_W-1:0] PKT_ADDR    = 7'h48;

  // Bit positions inside the status halfword
  localparam int ST_RX_READY  = 0;
  localparam int ST_RX_ACTIVE = 1;
  localparam int ST_TX_ACTIVE = 8;

  // Bit positions inside the error halfword
  localparam int ER_RX = 0;
  localparam int ER_TX = 8;

  // Target of one access as seen in the data phase
  typedef enum logic [2:0] {
    REG_BUF    = 3'd0,
    REG_STATUS = 3'd1,
    REG_ERROR  = 3'd2,
    REG_OCC    = 3'd3,
    REG_PKT    = 3'd4,
    REG_BAD    = 3'd5
  } region_e;

endpackage

`default_nettype wire

/* rtl/ahb_addr_decode.sv */
`default_nettype none

module ahb_addr_decode
  import usb_ahb_pkg::*;
#(
  parameter int ADDR_W = usb_ahb_pkg::ADDR_W
) (
  input  wire logic              tb_clk,
  input  wire logic              rst_i,
  // AHB address phase
  input  wire logic              hsel_i,
  input  wire logic [ADDR_W-1:0] haddr_i,
  input  htrans_e                htrans_i,
  input  hsize_e                 hsize_i,
  input  wire logic              hwrite_i,
  // Ready line as seen on the bus, fed back from the response FSM
  input  wire logic              hready_i,
  // Registered data-phase control
  output logic                   dphase_valid_o,
  output logic                   dphase_write_o,
  output region_e                dphase_region_o,
  output logic [1:0]             dphase_offset_o,
  output hsize_e                 dphase_size_o
);

  // First address past the register block
  localparam logic [ADDR_W-1:0] MAP_END = PKT_ADDR + ADDR_W'(REG_SPAN);

  // ********************************************************************
  // Address classification
  // ********************************************************************

  // Map one address and direction onto a target region
  // Read-only registers turn a write into REG_BAD
  function automatic region_e classify(input logic [ADDR_W-1:0] addr,
                                       input logic              wr);
    region_e sel;
    if (addr <= BUF_LAST) begin
      // Data window, read pops and write pushes
      sel = REG_BUF;
    end else if (addr < ERROR_ADDR) begin
      sel = wr ? REG_BAD : REG_STATUS;
    end else if (addr < OCC_ADDR) begin
      sel = wr ? REG_BAD : REG_ERROR;
    end else if (addr < PKT_ADDR) begin
      sel = wr ? REG_BAD : REG_OCC;
    end else if (addr < MAP_END) begin
      // Only writable register in the block
      sel = REG_PKT;
    end else begin
      // Unmapped space above the register block
      sel = REG_BAD;
    end
    return sel;
  endfunction

  logic    accept;
  region_e region_next;

  // Address phase is taken only for NONSEQ and SEQ
  // IDLE and BUSY fall through and leave no data phase behind
  assign accept = hsel_i && hready_i &&
                  ((htrans_i == NONSEQ) || (htrans_i == SEQ));

  assign region_next = classify(haddr_i, hwrite_i);

  // ********************************************************************
  // Data-phase control registers
  // ********************************************************************

  // Valid flag, cleared outside accepted phases
  // While hready is low the current data phase is held
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      dphase_valid_o <= 1'b0;
    end else if (hready_i) begin
      dphase_valid_o <= accept;
    end
  end

  // Payload of the data phase, only meaningful with the valid flag
  always_ff @(posedge tb_clk) begin
    if (accept) begin
      dphase_write_o  <= hwrite_i;
      dphase_region_o <= region_next;
      // Low address bits pick the byte lanes
      dphase_offset_o <= haddr_i[1:0];
      dphase_size_o   <= hsize_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/ahb_err_resp.sv */
`default_nettype none

module ahb_err_resp
  import usb_ahb_pkg::*;
(
  input  wire logic tb_clk,
  input  wire logic rst_i,
  // Data-phase control from the decoder
  input  wire logic dphase_valid_i,
  input  region_e   dphase_region_i,
  // AHB response
  output logic      hready_o,
  output logic      hresp_o
);

  // Response FSM states
  typedef enum logic [1:0] {
    OKAY       = 2'd0,
    ERR_FIRST  = 2'd1,
    ERR_SECOND = 2'd2
  } resp_state_e;

  resp_state_e state_q;
  resp_state_e state_cur;
  resp_state_e state_next;

  // ********************************************************************
  // Present state
  // ********************************************************************

  // A bad access must show hready low in its very first data cycle
  // So the first ERROR cycle is taken straight from the data-phase control
  always_comb begin
    state_cur = state_q;
    if ((state_q == OKAY) && dphase_valid_i && (dphase_region_i == REG_BAD)) begin
      state_cur = ERR_FIRST;
    end
  end

  // Next state, two ERROR cycles then back to OKAY
  always_comb begin
    case (state_cur)
      ERR_FIRST:  state_next = ERR_SECOND;
      ERR_SECOND: state_next = OKAY;
      default:    state_next = OKAY;
    endcase
  end

  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      state_q <= OKAY;
    end else begin
      state_q <= state_next;
    end
  end

  // ********************************************************************
  // Response outputs
  // ********************************************************************

  // First cycle stalls the master, second one completes the error
  always_comb begin
    case (state_cur)
      ERR_FIRST: begin
        hready_o = 1'b0;
        hresp_o  = 1'b1;
      end
      ERR_SECOND: begin
        hready_o = 1'b1;
        hresp_o  = 1'b1;
      end
      default: begin
        hready_o = 1'b1;
        hresp_o  = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ep_reg_file.sv */
`default_nettype none

module ep_reg_file
  import usb_ahb_pkg::*;
#(
  parameter int DATA_W = usb_ahb_pkg::DATA_W
) (
  input  wire logic              tb_clk,
  input  wire logic              rst_i,
  // Data-phase control from the decoder
  input  wire logic              dphase_valid_i,
  input  wire logic              dphase_write_i,
  input  region_e                dphase_region_i,
  input  wire logic [1:0]        dphase_offset_i,
  input  hsize_e                 dphase_size_i,
  // AHB write data, sampled at the end of the data phase
  input  wire logic [DATA_W-1:0] hwdata_i,
  // Endpoint inputs
  input  wire logic [DATA_W-1:0] rx_data_i,
  input  wire logic              rx_data_ready_i,
  input  wire logic              rx_active_i,
  input  wire logic              rx_error_i,
  input  wire logic              tx_active_i,
  input  wire logic              tx_error_i,
  input  wire logic [OCC_W-1:0]  buf_occupancy_i,
  // AHB read data
  output logic      [DATA_W-1:0] hrdata_o,
  // Buffer commands
  output logic                   get_rx_data_o,
  output logic                   store_tx_data_o,
  output logic      [DATA_W-1:0] tx_data_o,
  output hsize_e                 data_size_o,
  output logic      [OCC_W-1:0]  tx_pkt_size_o
);

  logic [HREG_W-1:0] status_q;
  logic [HREG_W-1:0] error_q;
  logic [OCC_W-1:0]  occ_q;
  logic [4:0]        byte_shift;
  logic [4:0]        half_shift;
  logic [DATA_W-1:0] wr_aligned;
  logic              rd_active;
  logic              wr_active;

  // Data phase qualifiers
  assign rd_active = dphase_valid_i && !dphase_write_i;
  assign wr_active = dphase_valid_i && dphase_write_i;

  // Word registers follow the full byte offset
  assign byte_shift = {dphase_offset_i, 3'b000};
  // Halfword registers sit on the lower or upper half of the word
  assign half_shift = {dphase_offset_i[1], 4'b0000};

  // ********************************************************************
  // Status sampling
  // ********************************************************************

  // Endpoint flags are sampled once per cycle into the register images
  always_ff @(posedge tb_clk) begin
    status_q               <= '0;
    status_q[ST_RX_READY]  <= rx_data_ready_i;
    status_q[ST_RX_ACTIVE] <= rx_active_i;
    status_q[ST_TX_ACTIVE] <= tx_active_i;
    error_q                <= '0;
    error_q[ER_RX]         <= rx_error_i;
    error_q[ER_TX]         <= tx_error_i;
    occ_q                  <= buf_occupancy_i;
  end

  // ********************************************************************
  // Read data and pop strobe
  // ********************************************************************

  // Read word is built during the data phase itself
  always_comb begin
    hrdata_o = '0;
    if (rd_active) begin
      case (dphase_region_i)
        // Buffer word goes out as presented
        REG_BUF:    hrdata_o = rx_data_i;
        REG_STATUS: hrdata_o = DATA_W'(status_q) << half_shift;
        REG_ERROR:  hrdata_o = DATA_W'(error_q) << half_shift;
        REG_OCC:    hrdata_o = DATA_W'(occ_q) << byte_shift;
        REG_PKT:    hrdata_o = DATA_W'(tx_pkt_size_o) << byte_shift;
        default:    hrdata_o = '0;
      endcase
    end
  end

  // Pop the receive buffer in the same cycle the word is returned
  assign get_rx_data_o = rd_active && (dphase_region_i == REG_BUF);

  // ********************************************************************
  // Writes
  // ********************************************************************

  // Bring the addressed byte lanes down to bit 0
  assign wr_aligned = hwdata_i >> byte_shift;

  // Push strobe, one cycle after the write data phase
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      store_tx_data_o <= 1'b0;
    end else begin
      store_tx_data_o <= wr_active && (dphase_region_i == REG_BUF);
    end
  end

  // Transmit word and size travel with the push strobe
  always_ff @(posedge tb_clk) begin
    if (wr_active && (dphase_region_i == REG_BUF)) begin
      tx_data_o   <= hwdata_i;
      data_size_o <= dphase_size_i;
    end
  end

  // Packet size register, the only writable register
  always_ff @(posedge tb_clk) begin
    if (rst_i) begin
      tx_pkt_size_o <= '0;
    end else if (wr_active && (dphase_region_i == REG_PKT)) begin
      tx_pkt_size_o <= wr_aligned[OCC_W-1:0];
    end
  end

endmodule

`default_nettype wire

/* rtl/usb_ahb_slave.sv */
`default_nettype none

module usb_ahb_slave
  import usb_ahb_pkg::*;
#(
  parameter int DATA_W = usb_ahb_pkg::DATA_W,
  parameter int ADDR_W = usb_ahb_pkg::ADDR_W
) (
  input  wire logic              tb_clk,
  input  wire logic              rst_i,
  // AHB-Lite slave side
  input  wire logic              hsel_i,
  input  wire logic [ADDR_W-1:0] haddr_i,
  input  htrans_e                htrans_i,
  input  hsize_e                 hsize_i,
  input  wire logic              hwrite_i,
  input  wire logic [DATA_W-1:0] hwdata_i,
  output logic      [DATA_W-1:0] hrdata_o,
  output logic                   hready_o,
  output logic                   hresp_o,
  // Endpoint status and receive buffer
  input  wire logic [DATA_W-1:0] rx_data_i,
  input  wire logic              rx_data_ready_i,
  input  wire logic              rx_active_i,
  input  wire logic              rx_error_i,
  input  wire logic              tx_active_i,
  input  wire logic              tx_error_i,
  input  wire logic [OCC_W-1:0]  buf_occupancy_i,
  // Endpoint buffer commands
  output logic                   get_rx_data_o,
  output logic                   store_tx_data_o,
  output logic      [DATA_W-1:0] tx_data_o,
  output hsize_e                 data_size_o,
  output logic      [OCC_W-1:0]  tx_pkt_size_o
);

  // Data-phase control shared by the response FSM and the register file
  logic       dphase_valid;
  logic       dphase_write;
  region_e    dphase_region;
  logic [1:0] dphase_offset;
  hsize_e     dphase_size;

  // ********************************************************************
  // Address phase capture
  // ********************************************************************

  // Ready line loops back so a stalled phase is not taken
  ahb_addr_decode #(
    .ADDR_W(ADDR_W)
  ) u_decode (
    .tb_clk          (tb_clk),
    .rst_i           (rst_i),
    .hsel_i          (hsel_i),
    .haddr_i         (haddr_i),
    .htrans_i        (htrans_i),
    .hsize_i         (hsize_i),
    .hwrite_i        (hwrite_i),
    .hready_i        (hready_o),
    .dphase_valid_o  (dphase_valid),
    .dphase_write_o  (dphase_write),
    .dphase_region_o (dphase_region),
    .dphase_offset_o (dphase_offset),
    .dphase_size_o   (dphase_size)
  );

  // Two-cycle ERROR response and ready line
  ahb_err_resp u_err_resp (
    .tb_clk          (tb_clk),
    .rst_i           (rst_i),
    .dphase_valid_i  (dphase_valid),
    .dphase_region_i (dphase_region),
    .hready_o        (hready_o),
    .hresp_o         (hresp_o)
  );

  // ********************************************************************
  // Registers and buffer strobes
  // ********************************************************************

  ep_reg_file #(
    .DATA_W(DATA_W)
  ) u_reg_file (
    .tb_clk          (tb_clk),
    .rst_i           (rst_i),
    .dphase_valid_i  (dphase_valid),
    .dphase_write_i  (dphase_write),
    .dphase_region_i (dphase_region),
    .dphase_offset_i (dphase_offset),
    .dphase_size_i   (dphase_size),
    .hwdata_i        (hwdata_i),
    .rx_data_i       (rx_data_i),
    .rx_data_ready_i (rx_data_ready_i),
    .rx_active_i     (rx_active_i),
    .rx_error_i      (rx_error_i),
    .tx_active_i     (tx_active_i),
    .tx_error_i      (tx_error_i),
    .buf_occupancy_i (buf_occupancy_i),
    .hrdata_o        (hrdata_o),
    .get_rx_data_o   (get_rx_data_o),
    .store_tx_data_o (store_tx_data_o),
    .tx_data_o       (tx_data_o),
    .data_size_o     (data_size_o),
    .tx_pkt_size_o   (tx_pkt_size_o)
  );

endmodule

`default_nettype wire

/* test/tb_usb_ahb_slave.sv */
`default_nettype none

module tb_usb_ahb_slave
  import usb_ahb_pkg::*;
();

  localparam int CLK_HALF        = 5;
  localparam int RST_CYCLES      = 4;
  localparam int DRIVE_DLY       = 1;
  localparam int MAX_TESTS       = 64;
  localparam int CYCLES_PER_TEST = 20;
  // Margin for the reset check and the closing cycles
  localparam int TAIL_CYCLES     = 10;

  logic              tb_clk;
  logic              rst_i;
  logic              hsel_i;
  logic [ADDR_W-1:0] haddr_i;
  htrans_e           htrans_i;
  hsize_e            hsize_i;
  logic              hwrite_i;
  logic [DATA_W-1:0] hwdata_i;
  logic [DATA_W-1:0] hrdata_o;
  logic              hready_o;
  logic              hresp_o;
  logic [DATA_W-1:0] rx_data_i;
  logic              rx_data_ready_i;
  logic              rx_active_i;
  logic              rx_error_i;
  logic              tx_active_i;
  logic              tx_error_i;
  logic [OCC_W-1:0]  buf_occupancy_i;
  logic              get_rx_data_o;
  logic              store_tx_data_o;
  logic [DATA_W-1:0] tx_data_o;
  hsize_e            data_size_o;
  logic [OCC_W-1:0]  tx_pkt_size_o;

  // Test table, one entry per data file line
  logic [8*16-1:0]   t_name   [MAX_TESTS];
  logic              t_write  [MAX_TESTS];
  logic [ADDR_W-1:0] t_addr   [MAX_TESTS];
  logic [1:0]        t_size   [MAX_TESTS];
  logic [DATA_W-1:0] t_wdata  [MAX_TESTS];
  logic [DATA_W-1:0] t_rxdata [MAX_TESTS];
  logic [2:0]        t_status [MAX_TESTS];
  logic [1:0]        t_errs   [MAX_TESTS];
  logic [OCC_W-1:0]  t_occ    [MAX_TESTS];
  logic [DATA_W-1:0] t_rdata  [MAX_TESTS];
  logic              t_resp   [MAX_TESTS];
  logic [OCC_W-1:0]  t_pkt    [MAX_TESTS];

  int    num_tests;
  int    mismatches;
  int    other_errors;
  logic  loaded;
  string cur_name;

  // ********************************************************************
  // DUT, clock and watchdog
  // ********************************************************************

  usb_ahb_slave #(
    .DATA_W(DATA_W),
    .ADDR_W(ADDR_W)
  ) dut0 (
    .tb_clk          (tb_clk),
    .rst_i           (rst_i),
    .hsel_i          (hsel_i),
    .haddr_i         (haddr_i),
    .htrans_i        (htrans_i),
    .hsize_i         (hsize_i),
    .hwrite_i        (hwrite_i),
    .hwdata_i        (hwdata_i),
    .hrdata_o        (hrdata_o),
    .hready_o        (hready_o),
    .hresp_o         (hresp_o),
    .rx_data_i       (rx_data_i),
    .rx_data_ready_i (rx_data_ready_i),
    .rx_active_i     (rx_active_i),
    .rx_error_i      (rx_error_i),
    .tx_active_i     (tx_active_i),
    .tx_error_i      (tx_error_i),
    .buf_occupancy_i (buf_occupancy_i),
    .get_rx_data_o   (get_rx_data_o),
    .store_tx_data_o (store_tx_data_o),
    .tx_data_o       (tx_data_o),
    .data_size_o     (data_size_o),
    .tx_pkt_size_o   (tx_pkt_size_o)
  );

  always #CLK_HALF tb_clk = ~tb_clk;

  // Run length follows the number of lines in the data file
  initial begin
    wait (loaded);
    repeat (num_tests * CYCLES_PER_TEST + RST_CYCLES + TAIL_CYCLES) @(posedge tb_clk);
    other_errors++;
    $display("Timeout: the transfers did not complete in the expected number of cycles");
    print_summary();
    $display("SOME TESTS FAILED");
    $finish;
  end

  // ********************************************************************
  // Helpers
  // ********************************************************************

  task automatic print_summary();
    $display("Errors: %0d value mismatches, %0d other failures", mismatches, other_errors);
  endtask

  task automatic check_val(input string what, input logic [DATA_W-1:0] exp,
                           input logic [DATA_W-1:0] act);
    assert (act === exp) else begin
      mismatches++;
      $display("FAIL %0s %0s: expected %h, actual %h", cur_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    assert (act === exp) else begin
      mismatches++;
      $display("FAIL %0s %0s: expected %b, actual %b", cur_name, what, exp, act);
    end
  endtask

  // Comment lines start with a lone # token
  task automatic load_tests();
    int               fd;
    logic             done;
    logic [8*16-1:0]  f_name;
    logic [8*128-1:0] rest;
    logic [31:0]      f_op;
    logic [31:0]      f_addr;
    logic [31:0]      f_size;
    logic [31:0]      f_wdata;
    logic [31:0]      f_rx;
    logic [31:0]      f_st;
    logic [31:0]      f_er;
    logic [31:0]      f_occ;
    logic [31:0]      f_rdata;
    logic [31:0]      f_resp;
    logic [31:0]      f_pkt;
    num_tests = 0;
    done      = 1'b0;
    fd = $fopen("test/slave_tests.dat", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the test data file test/slave_tests.dat");
      return;
    end
    while (!done) begin
      if ($fscanf(fd, "%s", f_name) != 1) begin
        done = 1'b1;
      end else if (f_name[7:0] == "#") begin
        // Rest of a comment line, nothing left means end of file
        if ($fgets(rest, fd) == 0) begin
          done = 1'b1;
        end
      end else if ($fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f_op, f_addr, f_size,
                           f_wdata, f_rx, f_st, f_er, f_occ, f_rdata, f_resp, f_pkt) == 11) begin
        t_name[num_tests]   = f_name;
        t_write[num_tests]  = f_op[0];
        t_addr[num_tests]   = f_addr[ADDR_W-1:0];
        t_size[num_tests]   = f_size[1:0];
        t_wdata[num_tests]  = f_wdata;
        t_rxdata[num_tests] = f_rx;
        t_status[num_tests] = f_st[2:0];
        t_errs[num_tests]   = f_er[1:0];
        t_occ[num_tests]    = f_occ[OCC_W-1:0];
        t_rdata[num_tests]  = f_rdata;
        t_resp[num_tests]   = f_resp[0];
        t_pkt[num_tests]    = f_pkt[OCC_W-1:0];
        num_tests++;
        done = (num_tests >= MAX_TESTS);
      end else begin
        other_errors++;
        $display("The test data file has a malformed line after %0d tests", num_tests);
        done = 1'b1;
      end
    end
    $fclose(fd);
    if (num_tests == 0) begin
      other_errors++;
      $display("The test data file holds no tests");
    end
  endtask

  // ********************************************************************
  // One NONSEQ transfer followed by IDLE
  // ********************************************************************

  task automatic run_transfer(input int i);
    logic is_buf;
    logic exp_get;
    logic exp_store;
    int   stall;
    cur_name  = string'(t_name[i]);
    is_buf    = (t_addr[i] <= BUF_LAST);
    // Strobes fire only for accepted window accesses
    exp_get   = !t_write[i] && is_buf && !t_resp[i];
    exp_store = t_write[i] && is_buf && !t_resp[i];
    // Address phase, endpoint status set up together with it
    @(posedge tb_clk);
    #DRIVE_DLY;
    hsel_i          = 1'b1;
    htrans_i        = NONSEQ;
    haddr_i         = t_addr[i];
    hsize_i         = hsize_e'(t_size[i]);
    hwrite_i        = t_write[i];
    // Buffer shows another word until the data phase
    rx_data_i       = ~t_rxdata[i];
    rx_data_ready_i = t_status[i][0];
    rx_active_i     = t_status[i][1];
    tx_active_i     = t_status[i][2];
    rx_error_i      = t_errs[i][0];
    tx_error_i      = t_errs[i][1];
    buf_occupancy_i = t_occ[i];
    // Accepting edge; master returns to IDLE and drives write data
    @(posedge tb_clk);
    #DRIVE_DLY;
    hsel_i    = 1'b0;
    htrans_i  = IDLE;
    haddr_i   = '0;
    hwrite_i  = 1'b0;
    hwdata_i  = t_wdata[i];
    // Receive word presented in the data phase itself
    rx_data_i = t_rxdata[i];
    // First data-phase cycle
    @(negedge tb_clk);
    check_bit("get_rx_data", exp_get, get_rx_data_o);
    check_bit("hready first", !t_resp[i], hready_o);
    check_bit("hresp first", t_resp[i], hresp_o);
    if (!t_write[i] && !t_resp[i]) begin
      check_val("hrdata", t_rdata[i], hrdata_o);
    end
    // Hold until the slave raises ready
    stall = 0;
    while (!hready_o) begin
      @(negedge tb_clk);
      stall++;
      check_bit("get_rx_data in error", 1'b0, get_rx_data_o);
    end
    check_val("wait cycles", DATA_W'(t_resp[i]), DATA_W'(stall));
    if (t_resp[i]) begin
      check_bit("hresp second", 1'b1, hresp_o);
    end
    // Cycle after the data phase
    @(negedge tb_clk);
    check_bit("store_tx_data", exp_store, store_tx_data_o);
    check_bit("hresp after", 1'b0, hresp_o);
    if (exp_store) begin
      check_val("tx_data", t_wdata[i], tx_data_o);
      check_val("data_size", DATA_W'(t_size[i]), DATA_W'(data_size_o));
    end
    check_val("tx_pkt_size", DATA_W'(t_pkt[i]), DATA_W'(tx_pkt_size_o));
    // Push strobe is a single cycle
    @(negedge tb_clk);
    check_bit("store_tx_data end", 1'b0, store_tx_data_o);
  endtask

  // ********************************************************************
  // Main sequence
  // ********************************************************************

  initial begin
    tb_clk          = 1'b0;
    rst_i           = 1'b1;
    hsel_i          = 1'b0;
    haddr_i         = '0;
    htrans_i        = IDLE;
    hsize_i         = WORD;
    hwrite_i        = 1'b0;
    hwdata_i        = '0;
    rx_data_i       = '0;
    rx_data_ready_i = 1'b0;
    rx_active_i     = 1'b0;
    rx_error_i      = 1'b0;
    tx_active_i     = 1'b0;
    tx_error_i      = 1'b0;
    buf_occupancy_i = '0;
    mismatches      = 0;
    other_errors    = 0;
    loaded          = 1'b0;
    cur_name        = "reset";
    load_tests();
    loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge tb_clk);
    #DRIVE_DLY;
    rst_i = 1'b0;
    // Idle bus state out of reset
    @(negedge tb_clk);
    check_bit("hready", 1'b1, hready_o);
    check_bit("hresp", 1'b0, hresp_o);
    check_bit("get_rx_data", 1'b0, get_rx_data_o);
    check_bit("store_tx_data", 1'b0, store_tx_data_o);
    check_val("tx_pkt_size", '0, DATA_W'(tx_pkt_size_o));
    for (int i = 0; i < num_tests; i++) begin
      run_transfer(i);
    end
    repeat (2) @(posedge tb_clk);
    print_summary();
    if ((mismatches == 0) && (other_errors == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/slave_tests.dat */
# name op(1=wr) addr size wdata rx_data status(rdy,act,txact) errs(rx,tx) occ rdata resp pkt
# all values hex; rdata is checked on OKAY reads, pkt is tx_pkt_size after the transfer
buf_wr_word     1 20 2 DEADBEEF 00000000 0 0 00 00000000 0 00
buf_wr_half     1 3E 1 5A5A0000 00000000 0 0 00 00000000 0 00
buf_wr_byte     1 03 0 C3000000 00000000 0 0 00 00000000 0 00
buf_rd_half     0 15 1 00000000 CAFE1234 1 0 08 CAFE1234 0 00
buf_rd_word     0 00 2 00000000 0BADF00D 1 0 07 0BADF00D 0 00
buf_rd_byte     0 3F 0 00000000 000000E7 1 0 06 000000E7 0 00
err_rd_tx       0 43 0 00000000 00000000 0 2 00 01000000 0 00
err_rd_rx       0 42 1 00000000 00000000 0 1 00 00010000 0 00
err_rd_both     0 42 2 00000000 00000000 0 3 00 01010000 0 00
err_rd_none     0 42 1 00000000 00000000 0 0 00 00000000 0 00
occ_rd_byte     0 44 0 00000000 00000000 0 0 2B 0000002B 0 00
occ_rd_lane2    0 46 0 00000000 00000000 0 0 11 00110000 0 00
occ_rd_word     0 44 2 00000000 00000000 0 0 7F 0000007F 0 00
status_rd_all   0 40 1 00000000 00000000 7 0 00 00000103 0 00
status_rd_rx    0 40 1 00000000 00000000 1 0 00 00000001 0 00
status_rd_tx    0 41 0 00000000 00000000 4 0 00 00000100 0 00
pkt_wr          1 48 2 0000002A 00000000 0 0 00 00000000 0 2A
pkt_rd          0 48 2 00000000 00000000 0 0 00 0000002A 0 2A
pkt_rd_lane1    0 49 0 00000000 00000000 0 0 00 00002A00 0 2A
pkt_wr_lane1    1 49 0 00001500 00000000 0 0 00 00000000 0 15
pkt_rd_lane_wr  0 48 2 00000000 00000000 0 0 00 00000015 0 15
pkt_wr_again    1 48 2 0000002A 00000000 0 0 00 00000000 0 2A
bad_wr_occ      1 44 2 0000007F 00000000 0 0 00 00000000 1 2A
bad_wr_status   1 40 1 0000FFFF 00000000 0 0 00 00000000 1 2A
bad_wr_error    1 43 0 FF000000 00000000 0 0 00 00000000 1 2A
bad_rd_unmapped 0 60 2 00000000 00000000 0 0 00 00000000 1 2A
bad_rd_4c       0 4C 2 00000000 00000000 0 0 00 00000000 1 2A
pkt_rd_keep     0 48 2 00000000 00000000 0 0 00 0000002A 0 2A

/* filelist.f */
rtl/usb_ahb_pkg.sv
rtl/ahb_addr_decode.sv
rtl/ahb_err_resp.sv
rtl/ep_reg_file.sv
rtl/usb_ahb_slave.sv
test/tb_usb_ahb_slave.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the AHB slave testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_usb_ahb_slave

rm -rf obj_dir "$LOG" build.log

verilator --binary --timing --assert -f filelist.f --top-module "$TOP" > build.log 2>&1 \
  && "./obj_dir/V$TOP" > "$LOG" 2>&1 \
  || { echo "Build or run error, see build.log and $LOG"; cat build.log; }

cat "$LOG" 2>/dev/null

grep -q "ALL TESTS PASSED" "$LOG" 2>/dev/null && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
